// ==== hdl/robot_ctrl_pkg.sv ====
////////////////////
// Shared widths, types, register map and timing constants for the robot control board
// Referenced by scoped name from every RTL file
////////////////////
package robot_ctrl_pkg;

    localparam int NUM_CHANNELS = 4;                // Servo, drive and fault channels

    ////////////////////
    // Data types
    ////////////////////
    typedef logic [5:0] reg_addr_t;                 // Register address
    typedef logic [7:0] reg_data_t;                 // Register data byte
    typedef logic [7:0] pwm_ratio_t;                // PWM high time in clocks
    typedef logic [7:0] drive_cmd_t;                // {brake, enable, direction, power[4:0]}
    typedef logic [7:0] baud_count_t;               // Baud divider counter

    ////////////////////
    // Timing
    ////////////////////
    localparam int BAUD_DIVISION  = 116;            // Clocks per UART bit, 115200 baud
    localparam int PWM_PERIOD     = 255;            // Clocks per PWM period
    localparam int SPI_FRAME_BITS = 16;             // R/W, spare, 6b addr, 8b data

    ////////////////////
    // Register map
    ////////////////////
    localparam reg_addr_t ADDR_SERVO_BASE  = 6'h00; // Servo positions 0..3
    localparam reg_addr_t ADDR_DRIVE_BASE  = 6'h04; // Drive commands 4..7
    localparam reg_addr_t ADDR_STATUS_CTRL = 6'h08; // LED control
    localparam reg_addr_t ADDR_FAULT       = 6'h09; // Rotation faults, read only

    // LED control register bits
    localparam int STATUS_TEST_BIT  = 0;            // LED test override
    localparam int STATUS_PI_BIT    = 1;            // Orange Pi connected
    localparam int STATUS_PS4_BIT   = 2;            // PS4 controller connected
    localparam int STATUS_FAULT_BIT = 3;            // Fault LED in test mode
    localparam int STATUS_HOT_BIT   = 4;            // Motor hot LED in test mode

    // State machines
    typedef enum logic [1:0] {SPI_IDLE, SPI_HEADER, SPI_DATA, SPI_WAIT_END} spi_state_t;
    typedef enum logic [1:0] {UART_START, UART_DATA, UART_STOP} uart_state_t;

endpackage

// ==== hdl/spi_slave.sv ====
////////////////////
// Mode 0 SPI slave, turns 16-bit host frames into register requests
// Reads request at bit 8, writes at bit 16, over a four-phase req/ack
////////////////////
module spi_slave (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      spi_clock,
    input  logic                      cs_n,
    input  logic                      mosi,
    output logic                      miso,
    output logic                      req,
    output logic                      write_en,
    output robot_ctrl_pkg::reg_addr_t address,
    output robot_ctrl_pkg::reg_data_t wr_data,
    input  logic                      ack,
    input  robot_ctrl_pkg::reg_data_t rd_data
);

    logic [1:0]                 sclk_sync;          // Two-flop synchronizers
    logic [1:0]                 cs_sync;
    logic [1:0]                 mosi_sync;
    logic                       sclk_prev;          // For edge detect
    logic                       sclk_rise;
    logic                       sclk_fall;
    logic [4:0]                 bit_count;          // Rising edges seen this frame
    logic [14:0]                shift_in;           // Earlier bits of the frame
    logic [15:0]                frame;              // Frame including the bit now sampled
    robot_ctrl_pkg::spi_state_t state;
    robot_ctrl_pkg::reg_data_t  miso_shift;         // Read data on its way out

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            sclk_sync <= '0;
            cs_sync   <= 2'b11;                     // Deselected
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_clock};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;
    assign frame     = {shift_in, mosi_sync[1]};

    ////////////////////
    // Frame FSM and request
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= robot_ctrl_pkg::SPI_IDLE;
            bit_count <= '0;
            shift_in  <= '0;
            req       <= 1'b0;
            write_en  <= 1'b0;
            address   <= '0;
            wr_data   <= '0;
        end else begin
            if (ack) req <= 1'b0;                   // Phase 3, drop once acked
            if (cs_sync[1]) begin
                state <= robot_ctrl_pkg::SPI_IDLE;  // Deselect aborts a partial frame
            end else begin
                case (state)
                    robot_ctrl_pkg::SPI_IDLE: begin
                        state     <= robot_ctrl_pkg::SPI_HEADER;
                        bit_count <= '0;
                        shift_in  <= '0;
                    end
                    robot_ctrl_pkg::SPI_HEADER: if (sclk_rise) begin
                        shift_in  <= frame[14:0];
                        bit_count <= bit_count + 5'd1;
                        if (bit_count == 5'(robot_ctrl_pkg::SPI_FRAME_BITS / 2 - 1)) begin
                            write_en <= frame[7];   // 1 is write
                            address  <= frame[5:0]; // Bit 6 is ignored
                            if (!frame[7] && !ack) req <= 1'b1;  // Read needs data early
                            state    <= robot_ctrl_pkg::SPI_DATA;
                        end
                    end
                    robot_ctrl_pkg::SPI_DATA: if (sclk_rise) begin
                        shift_in  <= frame[14:0];
                        bit_count <= bit_count + 5'd1;
                        if (bit_count == 5'(robot_ctrl_pkg::SPI_FRAME_BITS - 1)) begin
                            wr_data <= frame[7:0];
                            if (write_en && !ack) req <= 1'b1;
                            state   <= robot_ctrl_pkg::SPI_WAIT_END;
                        end
                    end
                    default: ;                      // Wait for cs_n high
                endcase
            end
        end
    end

    ////////////////////
    // MISO output
    ////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            miso       <= 1'b0;
            miso_shift <= '0;
        end else if (state == robot_ctrl_pkg::SPI_IDLE) begin
            miso       <= 1'b0;
            miso_shift <= '0;
        end else if (req && ack && !write_en) begin
            miso_shift <= rd_data;                  // Latch read byte on ack
        end else if (sclk_fall) begin
            miso       <= miso_shift[7];            // MSB first, host samples on rise
            miso_shift <= {miso_shift[6:0], 1'b0};
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
////////////////////
// Register file for servo, drive and LED control, answers the SPI req/ack handshake
// Also selects the four status LED levels
////////////////////
module reg_file (
    input  logic                       clock,
    input  logic                       reset_n,
    input  logic                       req,
    input  logic                       write_en,
    input  robot_ctrl_pkg::reg_addr_t  address,
    input  robot_ctrl_pkg::reg_data_t  wr_data,
    input  logic [robot_ctrl_pkg::NUM_CHANNELS-1:0] sr_fault,
    output logic                       ack,
    output robot_ctrl_pkg::reg_data_t  rd_data,
    output robot_ctrl_pkg::pwm_ratio_t servo_position [robot_ctrl_pkg::NUM_CHANNELS],
    output robot_ctrl_pkg::drive_cmd_t drive_cmd [robot_ctrl_pkg::NUM_CHANNELS],
    output logic                       status_fault,
    output logic                       status_pi,
    output logic                       status_ps4,
    output logic                       status_debug
);

    robot_ctrl_pkg::reg_data_t status_ctrl;         // LED control register
    logic                      led_test;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ack         <= 1'b0;
            status_ctrl <= '0;
            for (int i = 0; i < robot_ctrl_pkg::NUM_CHANNELS; i++) begin
                servo_position[i] <= '0;
                drive_cmd[i]      <= '0;
            end
        end else begin
            ack <= req;                             // Rises and falls one cycle after req
            if (req && !ack && write_en) begin      // Write on the ack rising edge
                for (int i = 0; i < robot_ctrl_pkg::NUM_CHANNELS; i++) begin
                    if (address == robot_ctrl_pkg::reg_addr_t'(
                            robot_ctrl_pkg::ADDR_SERVO_BASE + i))
                        servo_position[i] <= wr_data;
                    if (address == robot_ctrl_pkg::reg_addr_t'(
                            robot_ctrl_pkg::ADDR_DRIVE_BASE + i))
                        drive_cmd[i] <= wr_data;
                end
                if (address == robot_ctrl_pkg::ADDR_STATUS_CTRL)
                    status_ctrl <= wr_data;
            end
        end
    end

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        rd_data = '0;                               // Unmapped reads as zero
        for (int i = 0; i < robot_ctrl_pkg::NUM_CHANNELS; i++) begin
            if (address == robot_ctrl_pkg::reg_addr_t'(robot_ctrl_pkg::ADDR_SERVO_BASE + i))
                rd_data = servo_position[i];
            if (address == robot_ctrl_pkg::reg_addr_t'(robot_ctrl_pkg::ADDR_DRIVE_BASE + i))
                rd_data = drive_cmd[i];
        end
        if (address == robot_ctrl_pkg::ADDR_STATUS_CTRL)
            rd_data = status_ctrl;
        if (address == robot_ctrl_pkg::ADDR_FAULT)
            rd_data = robot_ctrl_pkg::reg_data_t'(sr_fault);  // Live fault pins
    end

    // Test override drives every LED from the control bits
    assign led_test     = status_ctrl[robot_ctrl_pkg::STATUS_TEST_BIT];
    assign status_fault = led_test ? status_ctrl[robot_ctrl_pkg::STATUS_FAULT_BIT] : |sr_fault;
    assign status_pi    = led_test ? 1'b1 : status_ctrl[robot_ctrl_pkg::STATUS_PI_BIT];
    assign status_ps4   = led_test ? 1'b1 : status_ctrl[robot_ctrl_pkg::STATUS_PS4_BIT];
    assign status_debug = led_test ? status_ctrl[robot_ctrl_pkg::STATUS_HOT_BIT] : 1'b1;

endmodule

// ==== hdl/servo_pwm.sv ====
////////////////////
// One arm servo PWM channel, ratio picked up at each period wrap
////////////////////
module servo_pwm (
    input  logic                       clock,
    input  logic                       reset_n,
    input  robot_ctrl_pkg::pwm_ratio_t ratio,
    output logic                       pwm_signal
);

    robot_ctrl_pkg::pwm_ratio_t count;              // 0 to PWM_PERIOD-1
    robot_ctrl_pkg::pwm_ratio_t ratio_q;            // Ratio for the current period

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count   <= '0;
            ratio_q <= '0;                          // Output low out of reset
        end else if (count == robot_ctrl_pkg::pwm_ratio_t'(robot_ctrl_pkg::PWM_PERIOD - 1)) begin
            count   <= '0;
            ratio_q <= ratio;                       // No mid-period glitch on update
        end else begin
            count   <= count + 1'b1;
        end
    end

    // High for ratio_q clocks from the period start
    assign pwm_signal = (count < ratio_q);

endmodule

// ==== hdl/drive_uart_tx.sv ====
////////////////////
// Drive motor UART transmitter, sends its command byte back to back in 8N1 frames
// Byte is sampled at each start bit
////////////////////
module drive_uart_tx (
    input  logic                       clock,
    input  logic                       reset_n,
    input  robot_ctrl_pkg::drive_cmd_t tx_data,
    output logic                       uart_tx
);

    robot_ctrl_pkg::uart_state_t state;
    robot_ctrl_pkg::baud_count_t baud_count;        // Clocks into the current bit
    logic [2:0]                  bit_count;         // Data bit index
    robot_ctrl_pkg::drive_cmd_t  tx_shift;          // Frame byte, LSB out first
    logic                        bit_done;

    assign bit_done = (baud_count ==
                       robot_ctrl_pkg::baud_count_t'(robot_ctrl_pkg::BAUD_DIVISION - 1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= robot_ctrl_pkg::UART_START;
            baud_count <= '0;
            bit_count  <= '0;
            tx_shift   <= '0;
            uart_tx    <= 1'b1;                     // Line idles high
        end else begin
            baud_count <= bit_done ? '0 : baud_count + 1'b1;

            // Drive the line at the start of each bit time
            if (baud_count == '0) begin
                case (state)
                    robot_ctrl_pkg::UART_START: begin
                        uart_tx  <= 1'b0;
                        tx_shift <= tx_data;        // Frame never mixes two commands
                    end
                    robot_ctrl_pkg::UART_DATA: begin
                        uart_tx  <= tx_shift[0];
                        tx_shift <= {1'b0, tx_shift[7:1]};
                    end
                    default: uart_tx <= 1'b1;       // Stop bit
                endcase
            end

            // Advance at the end of each bit time
            if (bit_done) begin
                case (state)
                    robot_ctrl_pkg::UART_START: begin
                        state     <= robot_ctrl_pkg::UART_DATA;
                        bit_count <= '0;
                    end
                    robot_ctrl_pkg::UART_DATA: begin
                        if (bit_count == 3'($bits(robot_ctrl_pkg::drive_cmd_t) - 1))
                            state <= robot_ctrl_pkg::UART_STOP;
                        bit_count <= bit_count + 3'd1;
                    end
                    default: state <= robot_ctrl_pkg::UART_START;  // Next frame right away
                endcase
            end
        end
    end

endmodule

// ==== hdl/robot_ctrl_top.sv ====
////////////////////
// Robot control board top, SPI register port driving servo PWM and drive UARTs
////////////////////
module robot_ctrl_top (
    input  logic                                    clock,
    input  logic                                    reset_n,
    input  logic                                    spi_clock,
    input  logic                                    cs_n,
    input  logic                                    mosi,
    output logic                                    miso,
    input  logic [robot_ctrl_pkg::NUM_CHANNELS-1:0] sr_fault,     // Rotation motor faults
    output logic [robot_ctrl_pkg::NUM_CHANNELS-1:0] servo_pwm,    // Arm servo PWM
    output logic [robot_ctrl_pkg::NUM_CHANNELS-1:0] sd_uart,      // Drive motor UART
    output logic                                    status_fault,
    output logic                                    status_pi,
    output logic                                    status_ps4,
    output logic                                    status_debug
);

    logic                       req;                // SPI to register file handshake
    logic                       ack;
    logic                       write_en;
    robot_ctrl_pkg::reg_addr_t  address;
    robot_ctrl_pkg::reg_data_t  wr_data;
    robot_ctrl_pkg::reg_data_t  rd_data;
    robot_ctrl_pkg::pwm_ratio_t servo_position [robot_ctrl_pkg::NUM_CHANNELS];
    robot_ctrl_pkg::drive_cmd_t drive_cmd [robot_ctrl_pkg::NUM_CHANNELS];

    spi_slave u_spi_slave (
        .clock    (clock),    .reset_n  (reset_n),
        .spi_clock(spi_clock), .cs_n    (cs_n),
        .mosi     (mosi),     .miso     (miso),
        .req      (req),      .write_en (write_en),
        .address  (address),  .wr_data  (wr_data),
        .ack      (ack),      .rd_data  (rd_data)
    );

    reg_file u_reg_file (
        .clock         (clock),          .reset_n     (reset_n),
        .req           (req),            .write_en    (write_en),
        .address       (address),        .wr_data     (wr_data),
        .sr_fault      (sr_fault),       .ack         (ack),
        .rd_data       (rd_data),        .servo_position (servo_position),
        .drive_cmd     (drive_cmd),      .status_fault (status_fault),
        .status_pi     (status_pi),      .status_ps4  (status_ps4),
        .status_debug  (status_debug)
    );

    // One servo channel and one drive UART per wheel module
    for (genvar i = 0; i < robot_ctrl_pkg::NUM_CHANNELS; i++) begin : gen_channel
        servo_pwm u_servo_pwm (
            .clock(clock), .reset_n(reset_n),
            .ratio(servo_position[i]), .pwm_signal(servo_pwm[i])
        );
        drive_uart_tx u_drive_uart_tx (
            .clock(clock), .reset_n(reset_n),
            .tx_data(drive_cmd[i]), .uart_tx(sd_uart[i])
        );
    end

endmodule

// ==== include/spi_host_tasks.svh ====
////////////////////
// SPI host frames, PWM high-time count and UART frame capture
// Included into the testbench module, uses its signals and check tasks
////////////////////
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

task automatic wait_clocks(input int count);
    repeat (count) begin
        @(posedge clock);
        #1;                                          // Drive and sample just after the edge
    end
endtask

////////////////////
// SPI mode 0 host
////////////////////
task automatic spi_frame(input logic write, input robot_ctrl_pkg::reg_addr_t addr,
                         input robot_ctrl_pkg::reg_data_t data,
                         output robot_ctrl_pkg::reg_data_t read_back);
    logic        spare;
    logic [15:0] frame;
    spare     = 1'(random_bits(1));                  // Bit 14 is don't care
    frame     = {write, spare, addr, data};
    read_back = '0;
    cs_n      = 1'b0;
    wait_clocks(SPI_HALF_PERIOD);
    for (int i = 15; i >= 0; i--) begin
        mosi = frame[i];                             // Changes while spi_clock low
        wait_clocks(SPI_HALF_PERIOD);
        if (i < 8)
            read_back[i] = miso;                     // Sampled at the rising edge
        spi_clock = 1'b1;
        wait_clocks(SPI_HALF_PERIOD);
        spi_clock = 1'b0;
    end
    wait_clocks(SPI_HALF_PERIOD);
    cs_n = 1'b1;
    mosi = 1'b0;
    wait_clocks(2 * SPI_HALF_PERIOD);                // Gap between frames
endtask

task automatic spi_write(input robot_ctrl_pkg::reg_addr_t addr,
                         input robot_ctrl_pkg::reg_data_t data);
    robot_ctrl_pkg::reg_data_t unused;
    spi_frame(1'b1, addr, data, unused);
endtask

task automatic spi_read(input robot_ctrl_pkg::reg_addr_t addr,
                        output robot_ctrl_pkg::reg_data_t data);
    spi_frame(1'b0, addr, 8'h00, data);
endtask

// Any window of one period holds exactly one high pulse
task automatic measure_pwm_high(input int channel, output int high);
    high = 0;
    for (int i = 0; i < robot_ctrl_pkg::PWM_PERIOD; i++) begin
        wait_clocks(1);
        if (pwm_out[channel])
            high++;
    end
endtask

////////////////////
// UART capture, all four lines in one frame
////////////////////
task automatic capture_uart_frames(output logic [31:0] bytes);
    logic [3:0] last;
    int         starts;
    last   = uart_out;
    starts = 0;
    bytes  = '0;
    for (int t = 0; t < 3 * FRAME_CYCLES && starts < 2; t++) begin
        wait_clocks(1);
        if (last == 4'hf && uart_out == 4'h0 &&
            ((cycle_count - frame_origin) % FRAME_CYCLES) == 0)
            starts++;                                // First start is skipped
        last = uart_out;
    end
    if (starts < 2)
        abort_run("Timeout: no frame-aligned start bit seen on the drive UART lines");
    wait_clocks(robot_ctrl_pkg::BAUD_DIVISION / 2);  // Middle of the start bit
    check_value("sd_uart start bit", uart_out, 4'h0);
    for (int b = 0; b < 8; b++) begin
        wait_clocks(robot_ctrl_pkg::BAUD_DIVISION);
        for (int ch = 0; ch < 4; ch++)
            bytes[ch * 8 + b] = uart_out[ch];        // LSB first
    end
    wait_clocks(robot_ctrl_pkg::BAUD_DIVISION);
    check_value("sd_uart stop bit", uart_out, 4'hf);
endtask

`endif

// ==== dv/robot_ctrl_tb.sv ====
////////////////////
// Testbench for the robot control top, random SPI traffic checked against a register model
// Also checks servo PWM, drive UART frames and status LEDs
////////////////////
module robot_ctrl_tb;

    localparam int SPI_HALF_PERIOD = 8;                  // Clocks per spi_clock half
    localparam int FRAME_CYCLES    = 10 * robot_ctrl_pkg::BAUD_DIVISION;  // 8N1 frame

    logic       clock;
    logic       reset_n;
    logic       spi_clock;
    logic       cs_n;
    logic       mosi;
    logic       miso;
    logic [3:0] sr_fault;
    logic [3:0] pwm_out;
    logic [3:0] uart_out;
    logic [3:0] status_out;                              // {fault, pi, ps4, debug}

    logic [31:0]               lfsr_state;
    robot_ctrl_pkg::reg_data_t model_regs [16];          // Writable registers 0 to 8
    int                        cycle_count  = 0;
    int                        frame_origin = 0;         // Cycle of the first start bit

    robot_ctrl_top uut (
        .clock       (clock),         .reset_n     (reset_n),
        .spi_clock   (spi_clock),     .cs_n        (cs_n),
        .mosi        (mosi),          .miso        (miso),
        .sr_fault    (sr_fault),      .servo_pwm   (pwm_out),
        .sd_uart     (uart_out),      .status_fault(status_out[3]),
        .status_pi   (status_out[2]), .status_ps4  (status_out[1]),
        .status_debug(status_out[0])
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle_count <= cycle_count + 1;

    ////////////////////
    // Random source and model
    ////////////////////
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            value      = {value[30:0], lfsr_state[0]};  // One step per bit
        end
        return value;
    endfunction

    function automatic void model_write(input robot_ctrl_pkg::reg_addr_t addr,
                                        input robot_ctrl_pkg::reg_data_t data);
        if (addr <= robot_ctrl_pkg::ADDR_STATUS_CTRL)
            model_regs[addr[3:0]] = data;                // Fault and unmapped ignore writes
    endfunction

    function automatic robot_ctrl_pkg::reg_data_t model_read(input robot_ctrl_pkg::reg_addr_t addr);
        if (addr == robot_ctrl_pkg::ADDR_FAULT)
            return {4'h0, sr_fault};
        if (addr <= robot_ctrl_pkg::ADDR_STATUS_CTRL)
            return model_regs[addr[3:0]];
        return '0;
    endfunction

    function automatic logic [3:0] expected_status(input logic [7:0] ctrl, input logic [3:0] fault);
        if (ctrl[robot_ctrl_pkg::STATUS_TEST_BIT])       // LED test override
            return {ctrl[robot_ctrl_pkg::STATUS_FAULT_BIT], 2'b11,
                    ctrl[robot_ctrl_pkg::STATUS_HOT_BIT]};
        return {|fault, ctrl[robot_ctrl_pkg::STATUS_PI_BIT],
                ctrl[robot_ctrl_pkg::STATUS_PS4_BIT], 1'b1};
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("[ERROR] %0t %s: got 0x%0h, expected 0x%0h",
                                $time, name, actual, expected));
        end
    endtask

    `include "spi_host_tasks.svh"

    ////////////////////
    // Test sequence
    ////////////////////
    initial begin
        robot_ctrl_pkg::reg_addr_t addr;
        robot_ctrl_pkg::reg_data_t data;
        robot_ctrl_pkg::reg_data_t read_data;
        logic [31:0]               drive_bytes;
        int                        high_time;
        reset_n    = 1'b0;
        spi_clock  = 1'b0;
        cs_n       = 1'b1;
        mosi       = 1'b0;
        lfsr_state = 32'h17d88c93;
        sr_fault   = 4'(random_bits(4));
        for (int i = 0; i < 16; i++)
            model_regs[i] = '0;
        repeat (8) @(posedge clock);
        #1 reset_n = 1'b1;

        // All drive lines start their first frame together
        for (int t = 0; t < 16 && uart_out == 4'hf; t++)
            wait_clocks(1);
        if (uart_out == 4'hf)
            abort_run("Timeout: drive UARTs sent no start bit after reset");
        check_value("sd_uart", uart_out, 4'h0);
        frame_origin = cycle_count;

        // Reset state
        for (int a = 0; a <= int'(robot_ctrl_pkg::ADDR_FAULT); a++) begin
            spi_read(6'(a), read_data);
            check_value($sformatf("rd_data addr %0d", a), read_data, model_read(6'(a)));
        end
        for (int ch = 0; ch < 4; ch++) begin
            measure_pwm_high(ch, high_time);
            check_value($sformatf("servo_pwm[%0d] high", ch), high_time, 0);
        end
        check_value("status_debug", status_out[0], 1'b1);
        check_value("status_fault", status_out[3], |sr_fault);

        // Random register traffic, some of it unmapped
        for (int n = 0; n < 40; n++) begin
            addr = (random_bits(1) != 0) ? 6'(random_bits(6)) : 6'(random_bits(4));
            data = 8'(random_bits(8));
            if (random_bits(2) == 0)
                sr_fault = 4'(random_bits(4));
            if (random_bits(1) != 0) begin
                spi_write(addr, data);
                model_write(addr, data);
            end else begin
                spi_read(addr, read_data);
                check_value($sformatf("rd_data addr %0d", addr), read_data, model_read(addr));
            end
        end

        // Servo PWM, new ratio visible within two periods
        for (int ch = 0; ch < 4; ch++) begin
            addr = 6'(robot_ctrl_pkg::ADDR_SERVO_BASE + ch);
            data = 8'(random_bits(8));
            spi_write(addr, data);
            model_write(addr, data);
        end
        wait_clocks(2 * robot_ctrl_pkg::PWM_PERIOD);
        for (int ch = 0; ch < 4; ch++) begin
            measure_pwm_high(ch, high_time);
            check_value($sformatf("servo_pwm[%0d] high", ch), high_time, model_regs[ch]);
        end

        // Drive UART commands
        for (int ch = 0; ch < 4; ch++) begin
            addr = 6'(robot_ctrl_pkg::ADDR_DRIVE_BASE + ch);
            data = 8'(random_bits(8));
            spi_write(addr, data);
            model_write(addr, data);
        end
        capture_uart_frames(drive_bytes);
        for (int ch = 0; ch < 4; ch++)
            check_value($sformatf("sd_uart[%0d] byte", ch), drive_bytes[ch * 8 +: 8],
                        model_regs[4 + ch]);

        // Status LEDs, test bit alternates
        for (int n = 0; n < 8; n++) begin
            data = 8'(random_bits(8));
            data[robot_ctrl_pkg::STATUS_TEST_BIT] = n[0];
            sr_fault = 4'(random_bits(4));
            spi_write(robot_ctrl_pkg::ADDR_STATUS_CTRL, data);
            model_write(robot_ctrl_pkg::ADDR_STATUS_CTRL, data);
            wait_clocks(1);
            check_value("status outputs", status_out, expected_status(model_regs[8], sr_fault));
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
hdl/robot_ctrl_pkg.sv
hdl/spi_slave.sv
hdl/reg_file.sv
hdl/servo_pwm.sv
hdl/drive_uart_tx.sv
hdl/robot_ctrl_top.sv
dv/robot_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run for the robot control testbench
VERILATOR ?= verilator
TOP       ?= robot_ctrl_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILE_LIST ?= list.f
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Simulation PASSED

SOURCES := $(wildcard hdl/*.sv dv/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# The log decides the result, the simulator status is not trusted alone
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
